//--- tb.f
hdl/opn_pkg.sv
hdl/opn_clock_gen.sv
hdl/opn_timer.sv
hdl/opn_timers.sv
hdl/opn_host_regs.sv
hdl/opn_top.sv
bench/tb_clock.sv
bench/opn_top_sva.sv
bench/opn_top_tb.sv

//--- Makefile
TOP = opn_top_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- bench/opn_top_tb.sv
module opn_top_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import opn_pkg::*;

    typedef enum logic [1:0] {
        ADDR_WR,
        DATA_WR,
        WAIT_CHK
    } kind_t;

    typedef struct packed {
        kind_t      kind;
        logic [7:0] regnum;
        logic [7:0] data;
        logic [7:0] waits;   // Zero periods for wait rows only
        status_t    exp;
    } row_t;

    localparam int ZP      = CEN_DIV * SLOTS;              // clk per zero period
    localparam int BUSY_LO = 1 + (BUSY_SLOTS - 1) * CEN_DIV;
    localparam int BUSY_HI = 1 + BUSY_SLOTS * CEN_DIV;
    localparam host_bus_t BUS_IDLE = '{din: 8'h00, addr: 2'b00, cs_n: 1'b1, wr_n: 1'b1};

    logic      clk;
    logic      rst;
    logic      cen;
    host_bus_t bus;
    status_t   dout;
    logic      irq_n;

    row_t    rows[$];
    status_t prev;        // Status expected before the current row
    int      cyc = 0;
    int      limit = 0;
    int      t_ref;       // Cycle of the last bus write
    int      status_errs;
    int      irq_errs;

    tb_clock #(.HALF_NS(10)) u_clock (.clk(clk));

    opn_top DUT (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .cen   ( cen   ),
        .bus   ( bus   ),
        .dout  ( dout  ),
        .irq_n ( irq_n )
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_status(input status_t got, input status_t exp, input string what);
        if (got !== exp) begin
            status_errs++;
            $display("FAILED at %0t: %s, dout %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            irq_errs++;
            $display("FAILED at %0t: %s, irq_n %b expected %b", $time, what, got, exp);
        end
    endtask

    // Shared pin is low while either flag is set
    function automatic logic irq_level(input status_t s);
        return !(s.flag_a || s.flag_b);
    endfunction

    function automatic logic [7:0] unrelated_reg();
        return 8'h28 + 8'($urandom % 216);   // 0x28 to 0xFF
    endfunction

    task automatic add_row(input kind_t kind, input logic [7:0] regnum, input logic [7:0] data,
                           input int waits, input logic [7:0] exp);
        row_t r;
        r.kind   = kind;
        r.regnum = regnum;
        r.data   = data;
        r.waits  = 8'(waits);
        r.exp    = status_t'(exp);
        rows.push_back(r);
    endtask

    task automatic build_table();
        int sum;
        add_row(ADDR_WR, 8'h24, 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'hff, 0, 8'h00);            // Timer A upper bits
        add_row(ADDR_WR, 8'h25, 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'h00, 0, 8'h00);            // A = 1020
        add_row(ADDR_WR, 8'h26, 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'hfe, 0, 8'h00);            // B = 254
        add_row(ADDR_WR, unrelated_reg(), 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'($urandom), 0, 8'h00);
        add_row(ADDR_WR, 8'h27, 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'h05, 0, 8'h00);            // Load A, irq A
        add_row(WAIT_CHK, 8'h00, 8'h00, 4, 8'h01);
        add_row(DATA_WR, 8'h00, 8'h0f, 0, 8'h01);            // A keeps running, load B
        add_row(WAIT_CHK, 8'h00, 8'h00, 32, 8'h03);
        add_row(DATA_WR, 8'h00, 8'h33, 0, 8'h00);            // Clear both, irqs off
        add_row(WAIT_CHK, 8'h00, 8'h00, 40, 8'h00);
        add_row(DATA_WR, 8'h00, 8'h00, 0, 8'h00);            // Stop both
        add_row(ADDR_WR, unrelated_reg(), 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'($urandom), 0, 8'h00);
        add_row(ADDR_WR, unrelated_reg(), 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'($urandom), 0, 8'h00);
        add_row(ADDR_WR, 8'h27, 8'h00, 0, 8'h00);
        add_row(DATA_WR, 8'h00, 8'h05, 0, 8'h00);            // Reload A from 1020
        add_row(WAIT_CHK, 8'h00, 8'h00, 4, 8'h01);
        add_row(DATA_WR, 8'h00, 8'h10, 0, 8'h00);
        sum = 0;
        foreach (rows[i]) begin
            sum += int'(rows[i].waits);
        end
        limit = (sum * ZP * 3) / 2 + 1000;
    endtask

    // One write cycle that returns on the edge sampling it
    task automatic bus_write(input logic port, input logic [7:0] value);
        @(posedge clk);
        bus <= '{din: value, addr: {1'b0, port}, cs_n: 1'b0, wr_n: 1'b0};
        @(negedge clk);
        t_ref = cyc;
        @(posedge clk);
        bus <= BUS_IDLE;
    endtask

    task automatic send_reg_number(input row_t r, input int idx);
        bus_write(1'b0, r.regnum);
        repeat (2) @(negedge clk);   // No busy from the address port
        check_status(dout, r.exp, $sformatf("row %0d address write", idx));
        check_irq(irq_n, irq_level(r.exp), $sformatf("row %0d address write", idx));
    endtask

    task automatic store_data_byte(input row_t r, input int idx);
        status_t rise;
        int      k;
        rise = prev;
        rise.busy = 1'b1;
        bus_write(1'b1, r.data);
        @(negedge clk);
        check_status(dout, rise, $sformatf("row %0d busy after data write", idx));
        while (dout.busy && cyc - t_ref < BUSY_HI) begin
            @(negedge clk);
        end
        k = cyc - t_ref;
        if (k <= BUSY_LO) begin
            status_errs++;
            $display("FAILED at %0t: row %0d busy low %0d clk after the write", $time, idx, k);
        end
        check_status(dout, r.exp, $sformatf("row %0d after busy", idx));
        check_irq(irq_n, irq_level(r.exp), $sformatf("row %0d after busy", idx));
    endtask

    task automatic watch_flag_window(input row_t r, input int idx);
        int lo;
        int hi;
        lo = t_ref + (int'(r.waits) - 1) * ZP;
        hi = t_ref + (int'(r.waits) + 1) * ZP;
        while (cyc < lo) begin
            @(negedge clk);
            if (dout !== prev) begin
                check_status(dout, prev, $sformatf("row %0d flag too early", idx));
                break;
            end
        end
        while (cyc < hi) begin
            @(negedge clk);
        end
        check_status(dout, r.exp, $sformatf("row %0d end of window", idx));
        check_irq(irq_n, irq_level(r.exp), $sformatf("row %0d end of window", idx));
    endtask

    initial begin
        rst = 1'b1;
        cen = 1'b1;
        bus = BUS_IDLE;
        status_errs = 0;
        irq_errs = 0;
        prev = '0;
        t_ref = 0;
        void'($urandom(69));
        build_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_status(dout, '0, "after reset");
        check_irq(irq_n, 1'b1, "after reset");
        foreach (rows[i]) begin
            case (rows[i].kind)
                ADDR_WR:  send_reg_number(rows[i], i);
                DATA_WR:  store_data_byte(rows[i], i);
                default:  watch_flag_window(rows[i], i);
            endcase
            prev = rows[i].exp;
        end
        repeat (2) @(posedge clk);
        $display("Errors: %0d status, %0d irq", status_errs, irq_errs);
        if (status_errs + irq_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run limit from the table's waits
    initial begin
        wait (limit > 0);
        while (cyc < limit) begin
            @(posedge clk);
        end
        $display("Timeout: the table was not done after %0d clock cycles", limit);
        $display("Errors: %0d status, %0d irq", status_errs, irq_errs);
        $display("Test failed");
        $finish;
    end

endmodule

//--- bench/opn_top_sva.sv
module opn_top_sva (
    input logic               clk,
    input logic               rst,
    input opn_pkg::host_bus_t bus,
    input opn_pkg::status_t   dout,
    input logic               irq_n
);
    timeunit 1ns;
    timeprecision 1ps;
    import opn_pkg::*;

    logic data_wr;

    assign data_wr = !bus.cs_n && !bus.wr_n && bus.addr[0];   // Either bank

    irq_idle_after_rst: assert property (@(posedge clk) rst |=> irq_n)
        else $error("irq_n is low in the cycle after reset");

    // Flags reach dout one clk after they drive irq_n
    irq_has_flag: assert property (@(posedge clk) disable iff (rst)
        !irq_n |=> (dout.flag_a || dout.flag_b))
        else $error("irq_n low without a flag in the status byte");

    busy_on_write: assert property (@(posedge clk) disable iff (rst) data_wr |=> dout.busy)
        else $error("busy not set after a data write");

endmodule

bind opn_top opn_top_sva u_sva (
    .clk   ( clk   ),
    .rst   ( rst   ),
    .bus   ( bus   ),
    .dout  ( dout  ),
    .irq_n ( irq_n )
);

//--- bench/tb_clock.sv
module tb_clock #(
    parameter int HALF_NS = 10   // Half of the 20 ns period
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_NS) clk = ~clk;

endmodule

//--- hdl/opn_top.sv
module opn_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,    // Leave at 1 if not needed
    input  opn_pkg::host_bus_t bus,
    output opn_pkg::status_t   dout,
    output logic               irq_n
);
    import opn_pkg::*;

    logic       clk_en;
    logic       zero;    // Start of each slot pass
    timer_cfg_t cfg;
    logic       clr_a;
    logic       clr_b;
    logic [1:0] flags;

    opn_clock_gen u_clock_gen (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .zero   ( zero   )
    );

    opn_host_regs u_host_regs (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .clk_en ( clk_en ),
        .bus    ( bus    ),
        .flags  ( flags  ),
        .cfg    ( cfg    ),
        .clr_a  ( clr_a  ),
        .clr_b  ( clr_b  ),
        .dout   ( dout   )
    );

    opn_timers u_timers (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .clk_en ( clk_en ),
        .zero   ( zero   ),
        .cfg    ( cfg    ),
        .clr_a  ( clr_a  ),
        .clr_b  ( clr_b  ),
        .flags  ( flags  ),
        .irq_n  ( irq_n  )
    );

endmodule

//--- hdl/opn_host_regs.sv
module opn_host_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  opn_pkg::host_bus_t  bus,
    input  logic [1:0]          flags,   // {flag_b, flag_a}
    output opn_pkg::timer_cfg_t cfg,
    output logic                clr_a,
    output logic                clr_b,
    output opn_pkg::status_t    dout
);
    import opn_pkg::*;

    logic              write;
    logic              addr_wr;
    logic              data_wr;
    logic              bank0_wr;
    timer_ctl_t        din_ctl;
    logic [7:0]        reg_sel;
    logic [7:0]        ta_hi;
    logic [1:0]        ta_lo;
    logic [TB_W-1:0]   tb_val;
    timer_ctl_t        ctl;
    logic              busy;
    logic              busy_nxt;
    logic [BUSY_W-1:0] busy_cnt;
    logic [BUSY_W-1:0] busy_cnt_nxt;

    assign write    = !bus.cs_n && !bus.wr_n;
    assign addr_wr  = write && !bus.addr[1] && !bus.addr[0];
    assign data_wr  = write && bus.addr[0];        // Either bank
    assign bank0_wr = data_wr && !bus.addr[1];     // Second bank holds nothing here
    assign din_ctl  = timer_ctl_t'(bus.din);

    // Register number latch
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_sel <= '0;
        end else if (addr_wr) begin
            reg_sel <= bus.din;
        end
    end

    // Timer values
    always_ff @(posedge clk) begin
        if (bank0_wr) begin
            case (reg_sel)
                REG_TA_HI: ta_hi  <= bus.din;
                REG_TA_LO: ta_lo  <= bus.din[1:0];
                REG_TB:    tb_val <= bus.din;
                default: ;
            endcase
        end
    end

    // Reset bits of register 0x27 become one-clk clear strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            ctl   <= '0;
            clr_a <= 1'b0;
            clr_b <= 1'b0;
        end else begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
            if (bank0_wr && reg_sel == REG_TIMER_CTL) begin
                ctl <= '{ch3_mode: din_ctl.ch3_mode,
                         rst_b:    1'b0,
                         rst_a:    1'b0,
                         irq_en_b: din_ctl.irq_en_b,
                         irq_en_a: din_ctl.irq_en_a,
                         load_b:   din_ctl.load_b,
                         load_a:   din_ctl.load_a};
                clr_a <= din_ctl.rst_a;
                clr_b <= din_ctl.rst_b;
            end
        end
    end

    assign cfg.value_a = {ta_hi, ta_lo};   // 0x24 holds the upper 8 bits
    assign cfg.value_b = tb_val;
    assign cfg.ctl     = ctl;

    // Busy counter
    // A new data write restarts the count even while busy
    always_comb begin
        busy_nxt     = busy;
        busy_cnt_nxt = busy_cnt;
        if (data_wr) begin
            busy_nxt     = 1'b1;
            busy_cnt_nxt = '0;
        end else if (busy && clk_en) begin
            busy_cnt_nxt = busy_cnt + 1'b1;
            if (busy_cnt == BUSY_W'(BUSY_SLOTS - 1)) begin
                busy_nxt = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else begin
            busy     <= busy_nxt;
            busy_cnt <= busy_cnt_nxt;
        end
    end

    // Busy bit of the status byte tracks the write on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
        end else begin
            dout <= '{busy: busy_nxt, rsvd: '0, flag_b: flags[1], flag_a: flags[0]};
        end
    end

endmodule

//--- hdl/opn_timers.sv
module opn_timers (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  logic                zero,
    input  opn_pkg::timer_cfg_t cfg,
    input  logic                clr_a,
    input  logic                clr_b,
    output logic [1:0]          flags,   // {flag_b, flag_a}
    output logic                irq_n
);
    import opn_pkg::*;

    logic tick;

    // One tick per full slot pass
    assign tick = zero && clk_en;

    opn_timer #(
        .W        ( TA_W        ),
        .PRESCALE ( 1           )
    ) u_timer_a (
        .clk    ( clk              ),
        .rst    ( rst              ),
        .tick   ( tick             ),
        .value  ( cfg.value_a      ),
        .load   ( cfg.ctl.load_a   ),
        .irq_en ( cfg.ctl.irq_en_a ),
        .clr    ( clr_a            ),
        .flag   ( flags[0]         )
    );

    opn_timer #(
        .W        ( TB_W        ),
        .PRESCALE ( TB_PRESCALE )   // Timer B runs 16x slower
    ) u_timer_b (
        .clk    ( clk              ),
        .rst    ( rst              ),
        .tick   ( tick             ),
        .value  ( cfg.value_b      ),
        .load   ( cfg.ctl.load_b   ),
        .irq_en ( cfg.ctl.irq_en_b ),
        .clr    ( clr_b            ),
        .flag   ( flags[1]         )
    );

    // Shared interrupt pin
    assign irq_n = ~|flags;

endmodule

//--- hdl/opn_timer.sv
module opn_timer #(
    parameter int W        = 10,
    parameter int PRESCALE = 1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         tick,
    input  logic [W-1:0] value,
    input  logic         load,
    input  logic         irq_en,
    input  logic         clr,
    output logic         flag
);

    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic             load_q;
    logic             load_rise;
    logic             run;
    logic [PRE_W-1:0] pre;
    logic             pre_end;
    logic             step;
    logic [W-1:0]     cnt;
    logic             ovf;

    assign load_rise = load && !load_q;
    assign run       = load && load_q;        // Counting only after the load edge
    assign pre_end   = pre == PRE_W'(PRESCALE - 1);
    assign step      = run && tick && pre_end;
    assign ovf       = step && (&cnt);        // Tick at full count

    // Prescaler and counter
    always_ff @(posedge clk) begin
        if (rst) begin
            load_q <= 1'b0;
            pre    <= '0;
            cnt    <= '0;
        end else begin
            load_q <= load;
            if (load_rise) begin
                cnt <= value;
                pre <= '0;
            end else if (run && tick) begin
                if (pre_end) begin
                    pre <= '0;
                    cnt <= ovf ? value : cnt + 1'b1;   // Reload on overflow
                end else begin
                    pre <= pre + 1'b1;
                end
            end
        end
    end

    // Flag holds until the CPU clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            flag <= 1'b0;
        end else if (clr) begin
            flag <= 1'b0;                  // Clear beats a same-cycle overflow
        end else if (ovf && irq_en) begin
            flag <= 1'b1;
        end
    end

endmodule

//--- hdl/opn_clock_gen.sv
module opn_clock_gen (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic clk_en,
    output logic zero
);
    import opn_pkg::*;

    logic [CEN_DIV_W-1:0] div;
    logic [SLOT_W-1:0]    slot;
    logic                 div_end;
    logic                 slot_end;

    assign div_end  = div == CEN_DIV_W'(CEN_DIV - 1);
    assign slot_end = slot == SLOT_W'(SLOTS - 1);

    // One clk_en per CEN_DIV cen pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            div    <= '0;
            clk_en <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            if (cen) begin
                if (div_end) begin
                    div    <= '0;
                    clk_en <= 1'b1;
                end else begin
                    div <= div + 1'b1;
                end
            end
        end
    end

    // Operator slot counter
    // zero lands on the clk_en pulse that closes slot SLOTS-1
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
            zero <= 1'b0;
        end else begin
            zero <= 1'b0;
            if (cen && div_end) begin
                zero <= slot_end;
                if (slot_end) begin
                    slot <= '0;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/opn_pkg.sv
package opn_pkg;

    // Timer widths
    localparam int TA_W = 10;
    localparam int TB_W = 8;

    // Clock enable rhythm
    localparam int CEN_DIV     = 6;    // cen pulses per clk_en
    localparam int SLOTS       = 24;   // 6 channels x 4 operators
    localparam int TB_PRESCALE = 16;   // zero pulses per timer B count
    localparam int BUSY_SLOTS  = 32;   // clk_en pulses of busy after a write

    localparam int CEN_DIV_W = $clog2(CEN_DIV);
    localparam int SLOT_W    = $clog2(SLOTS);
    localparam int BUSY_W    = $clog2(BUSY_SLOTS);

    // Timer register map of bank 0
    localparam logic [7:0] REG_TA_HI     = 8'h24;
    localparam logic [7:0] REG_TA_LO     = 8'h25;
    localparam logic [7:0] REG_TB        = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL = 8'h27;

    // CPU side of the chip
    typedef struct packed {
        logic [7:0] din;
        logic [1:0] addr;   // addr[0] data port, addr[1] second bank
        logic       cs_n;
        logic       wr_n;
    } host_bus_t;

    // Register 0x27
    typedef struct packed {
        logic [1:0] ch3_mode;   // Channel 3 mode is not used here
        logic       rst_b;
        logic       rst_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;
        logic       load_a;
    } timer_ctl_t;

    // Timer setup handed from the host registers to the timers
    typedef struct packed {
        logic [TA_W-1:0] value_a;
        logic [TB_W-1:0] value_b;
        timer_ctl_t      ctl;
    } timer_cfg_t;

    // Status byte as read by the CPU
    typedef struct packed {
        logic       busy;
        logic [4:0] rsvd;   // Always zero
        logic       flag_b;
        logic       flag_a;
    } status_t;

endpackage
